/* files.f */
+incdir+rtl
rtl/tetris_pkg.sv
rtl/piece_shape_rom.sv
rtl/drop_scanner.sv
rtl/action_state_update.sv
testbench/tb_action_state_update.sv

/* rtl/action_state_update.sv */
// ==============================
// action state update
// next piece state for one player
// action, plus the ghost cells at
// the landing row
// ==============================

`timescale 1ns/1ps

`include "tetris_params.svh"

module action_state_update
    import tetris_pkg::*;
(
    input  logic                                       clk,
    input  logic                                       rst_n,

    input  logic                                       req_valid,
    output logic                                       req_ready,
    input  tile_type_t                                 req_type,
    input  orientation_t                               req_orientation,
    input  coord_t                                     req_row,
    input  coord_t                                     req_col,
    input  action_t                                    req_action,
    input  logic [`PLAYFIELD_ROWS*`PLAYFIELD_COLS-1:0] locked_occ,

    output logic                                       resp_valid,
    input  logic                                       resp_ready,
    output coord_t                                     resp_row,
    output coord_t                                     resp_col,
    output orientation_t                               resp_orientation,
    output cell_t                                      ghost_rows [4],
    output cell_t                                      ghost_cols [4]
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        SCAN = 2'd1,
        RESP = 2'd2
    } state_t;

    state_t       state;

    tile_type_t   cap_type;
    orientation_t cap_orientation;
    coord_t       cap_row;
    coord_t       cap_col;
    action_t      cap_action;

    logic         scan_start;
    logic         scan_done;
    coord_t       land_row;

    coord_t       next_row;
    coord_t       next_col;
    orientation_t next_orientation;
    cell_t        ghost_rows_c [4];
    cell_t        ghost_cols_c [4];

    assign req_ready  = (state == IDLE);
    assign resp_valid = (state == RESP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            scan_start <= 1'b0;
        end else begin
            scan_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state      <= SCAN;
                        scan_start <= 1'b1;
                    end
                end
                SCAN: begin
                    if (scan_done) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (resp_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cap_type        <= req_type;
            cap_orientation <= req_orientation;
            cap_row         <= req_row;
            cap_col         <= req_col;
            cap_action      <= req_action;
        end
        // response payload holds through any stall
        if (scan_done) begin
            resp_row         <= next_row;
            resp_col         <= next_col;
            resp_orientation <= next_orientation;
            for (int i = 0; i < 4; i++) begin
                ghost_rows[i] <= ghost_rows_c[i];
                ghost_cols[i] <= ghost_cols_c[i];
            end
        end
    end

    drop_scanner scanner (
        .clk               (clk),
        .rst_n             (rst_n),
        .scan_start        (scan_start),
        .piece_type        (cap_type),
        .piece_orientation (cap_orientation),
        .start_row         (cap_row),
        .piece_col         (cap_col),
        .locked_occ        (locked_occ),
        .scan_done         (scan_done),
        .land_row          (land_row)
    );

    // target state, no legality check
    always_comb begin
        next_row         = cap_row;
        next_col         = cap_col;
        next_orientation = cap_orientation;
        case (cap_action)
            ROTATE_R:  next_orientation = orientation_t'(cap_orientation + 2'd1);
            ROTATE_L:  next_orientation = orientation_t'(cap_orientation - 2'd1);
            MOVE_R:    next_col         = cap_col + coord_t'(1);
            MOVE_L:    next_col         = cap_col - coord_t'(1);
            SOFT_DROP: next_row         = cap_row + coord_t'(1);
            HARD_DROP: next_row         = land_row;
            default: ;
        endcase
    end

    // ghost is the current piece moved down to the landing row
    piece_shape_rom ghost_rom (
        .piece_type        (cap_type),
        .piece_orientation (cap_orientation),
        .origin_row        (land_row),
        .origin_col        (cap_col),
        .cell_rows         (ghost_rows_c),
        .cell_cols         (ghost_cols_c)
    );

endmodule

/* rtl/drop_scanner.sv */
// ==============================
// drop scanner
// walks a piece down one row per
// cycle and reports its landing row
// ==============================

`timescale 1ns/1ps

`include "tetris_params.svh"

module drop_scanner
    import tetris_pkg::*;
(
    input  logic                                       clk,
    input  logic                                       rst_n,

    input  logic                                       scan_start,
    input  tile_type_t                                 piece_type,
    input  orientation_t                               piece_orientation,
    input  coord_t                                     start_row,
    input  coord_t                                     piece_col,
    input  logic [`PLAYFIELD_ROWS*`PLAYFIELD_COLS-1:0] locked_occ,

    output logic                                       scan_done,
    output coord_t                                     land_row
);

    logic   busy;
    logic   start_blocked;
    coord_t cand_row;
    coord_t probe_row;
    logic   probe_free;
    cell_t  probe_rows [4];
    cell_t  probe_cols [4];

    // start row while idle, then the row under the last free one
    assign probe_row = busy ? coord_t'(cand_row + coord_t'(1)) : start_row;

    piece_shape_rom probe_rom (
        .piece_type        (piece_type),
        .piece_orientation (piece_orientation),
        .origin_row        (probe_row),
        .origin_col        (piece_col),
        .cell_rows         (probe_rows),
        .cell_cols         (probe_cols)
    );

    // cells above the board never block
    function automatic logic cell_free(input cell_t row, input cell_t col);
        int   idx;
        logic free;
        idx = int'(row) * `PLAYFIELD_COLS + int'(col);
        if (row < 0) begin
            free = 1'b1;
        end else if (col < 0 || col >= `PLAYFIELD_COLS || row >= `PLAYFIELD_ROWS) begin
            free = 1'b0;
        end else begin
            free = !locked_occ[idx];
        end
        return free;
    endfunction

    always_comb begin
        probe_free = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (!cell_free(probe_rows[i], probe_cols[i])) begin
                probe_free = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            start_blocked <= 1'b0;
            scan_done     <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            if (scan_start && !busy) begin
                busy          <= 1'b1;
                start_blocked <= !probe_free;
            end else if (busy) begin
                // blocked start still takes one busy cycle
                if (start_blocked || !probe_free) begin
                    busy      <= 1'b0;
                    scan_done <= 1'b1;
                end
            end
        end
    end

    // last row known to be free
    always_ff @(posedge clk) begin
        if (scan_start && !busy) begin
            cand_row <= start_row;
        end else if (busy && !start_blocked && probe_free) begin
            cand_row <= probe_row;
        end
    end

    assign land_row = cand_row;

endmodule

/* rtl/piece_shape_rom.sv */
// ==============================
// piece shape table
// absolute cell coordinates of a
// tetromino from type, orientation
// and origin
// ==============================

`timescale 1ns/1ps

module piece_shape_rom
    import tetris_pkg::*;
(
    input  tile_type_t   piece_type,
    input  orientation_t piece_orientation,
    input  coord_t       origin_row,
    input  coord_t       origin_col,

    output cell_t        cell_rows [4],
    output cell_t        cell_cols [4]
);

    localparam cell_t NEG2 = cell_t'(-2);
    localparam cell_t NEG1 = cell_t'(-1);
    localparam cell_t ZERO = cell_t'(0);
    localparam cell_t POS1 = cell_t'(1);

    cell_t base_rows [4];
    cell_t base_cols [4];
    cell_t rot_rows  [4];
    cell_t rot_cols  [4];

    // spawn orientation offsets, row grows downward
    always_comb begin
        case (piece_type)
            I: begin
                base_rows = '{ZERO, ZERO, ZERO, ZERO};
                base_cols = '{NEG2, NEG1, ZERO, POS1};
            end
            O: begin
                base_rows = '{ZERO, ZERO, NEG1, NEG1};
                base_cols = '{NEG1, ZERO, NEG1, ZERO};
            end
            T: begin
                base_rows = '{ZERO, ZERO, ZERO, NEG1};
                base_cols = '{NEG1, ZERO, POS1, ZERO};
            end
            J: begin
                base_rows = '{ZERO, ZERO, ZERO, NEG1};
                base_cols = '{NEG1, ZERO, POS1, NEG1};
            end
            L: begin
                base_rows = '{ZERO, ZERO, ZERO, NEG1};
                base_cols = '{NEG1, ZERO, POS1, POS1};
            end
            S: begin
                base_rows = '{ZERO, ZERO, NEG1, NEG1};
                base_cols = '{NEG1, ZERO, ZERO, POS1};
            end
            Z: begin
                base_rows = '{NEG1, NEG1, ZERO, ZERO};
                base_cols = '{NEG1, ZERO, ZERO, POS1};
            end
            default: begin
                base_rows = '{ZERO, ZERO, ZERO, ZERO};
                base_cols = '{ZERO, ZERO, ZERO, ZERO};
            end
        endcase
    end

    // each clockwise step takes (r, c) to (c, -r)
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rot_rows[i] = base_rows[i];
            rot_cols[i] = base_cols[i];
            // O looks the same in every orientation
            if (piece_type != O) begin
                case (piece_orientation)
                    ORIENTATION_R: begin
                        rot_rows[i] = base_cols[i];
                        rot_cols[i] = -base_rows[i];
                    end
                    ORIENTATION_2: begin
                        rot_rows[i] = -base_rows[i];
                        rot_cols[i] = -base_cols[i];
                    end
                    ORIENTATION_L: begin
                        rot_rows[i] = -base_cols[i];
                        rot_cols[i] = base_rows[i];
                    end
                    default: ;
                endcase
            end
        end
    end

    // signed sum keeps off-board cells visible
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            cell_rows[i] = cell_t'(origin_row) + rot_rows[i];
            cell_cols[i] = cell_t'(origin_col) + rot_cols[i];
        end
    end

endmodule

/* rtl/tetris_params.svh */
// ==============================
// tetris playfield parameters
// board size and coordinate widths
// ==============================

`ifndef TETRIS_PARAMS_SVH
`define TETRIS_PARAMS_SVH

// playfield height in rows, row 0 at the top
`define PLAYFIELD_ROWS 20

// playfield width in columns
`define PLAYFIELD_COLS 10

// unsigned on-board row or column
`define COORD_W 5

// signed piece cell coordinate, wide enough for cells off the board
`define CELL_W 6

`endif

/* rtl/tetris_pkg.sv */
// ==============================
// tetris shared types
// piece, orientation, action and
// coordinate types for the action path
// ==============================

`include "tetris_params.svh"

package tetris_pkg;

    // falling piece type
    typedef enum logic [2:0] {
        I = 3'd0,
        O = 3'd1,
        T = 3'd2,
        J = 3'd3,
        L = 3'd4,
        S = 3'd5,
        Z = 3'd6
    } tile_type_t;

    // clockwise order, so +1 is a right rotation
    typedef enum logic [1:0] {
        ORIENTATION_0 = 2'd0,
        ORIENTATION_R = 2'd1,
        ORIENTATION_2 = 2'd2,
        ORIENTATION_L = 2'd3
    } orientation_t;

    // player action for one request
    typedef enum logic [2:0] {
        ROTATE_R  = 3'd0,
        ROTATE_L  = 3'd1,
        MOVE_R    = 3'd2,
        MOVE_L    = 3'd3,
        SOFT_DROP = 3'd4,
        HARD_DROP = 3'd5
    } action_t;

    typedef logic [`COORD_W-1:0] coord_t;

    // may go negative or past the board edge
    typedef logic signed [`CELL_W-1:0] cell_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the action state update testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_action_state_update \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* testbench/action_trace.txt */
# req: name type orient row col action exp_row exp_col exp_orient then four ghost (row col)
# board: row mask, mask in binary with bit c for column c; clear empties the board
clear
req rot_r_t0 2 0 0 4 0 0 4 1 19 3 19 4 19 5 18 4
req rot_r_tr 2 1 1 4 0 1 4 2 17 4 18 4 19 4 18 5
req rot_l_t2 2 2 1 4 1 1 4 1 18 5 18 4 18 3 19 4
req rot_r_tl 2 3 1 4 0 1 4 0 19 4 18 4 17 4 18 3
req rot_l_t0 2 0 0 4 1 0 4 3 19 3 19 4 19 5 18 4
req move_r_j0 3 0 2 4 2 2 5 0 19 3 19 4 19 5 18 3
req move_l_jr 3 1 2 4 3 2 3 1 17 4 18 4 19 4 17 5
req soft_j2 3 2 2 4 4 3 4 2 18 5 18 4 18 3 19 5
req hard_jl 3 3 2 4 5 18 4 3 19 4 18 4 17 4 19 3
req hard_i0 0 0 0 5 5 19 5 0 19 3 19 4 19 5 19 6
req move_r_ir 0 1 2 5 2 2 6 1 16 5 17 5 18 5 19 5
req soft_i2 0 2 0 4 4 1 4 2 19 6 19 5 19 4 19 3
req rot_l_il 0 3 1 4 1 1 4 2 19 4 18 4 17 4 16 4
clear
board 19 0111111111
board 18 0000111111
board 17 0000000111
board 16 0000000001
req hard_i_step 0 0 0 7 5 17 7 0 17 5 17 6 17 7 17 8
req hard_o_step 1 0 0 9 5 18 9 0 18 8 18 9 17 8 17 9
req hard_t_step 2 0 0 4 5 17 4 0 17 3 17 4 17 5 16 4
req hard_j_step 3 0 0 2 5 16 2 0 16 1 16 2 16 3 15 1
req hard_l_step 4 0 0 7 5 18 7 0 18 6 18 7 18 8 17 8
req hard_s_step 5 0 0 1 5 15 1 0 15 0 15 1 14 1 14 2
req hard_z_step 6 0 0 4 5 17 4 0 16 3 16 4 17 4 17 5
req hard_t_rest 2 0 17 4 5 17 4 0 17 3 17 4 17 5 16 4
req hard_o_blocked 1 0 17 1 5 17 1 0 17 0 17 1 16 0 16 1
req rot_r_il_step 0 3 0 9 0 0 9 0 19 9 18 9 17 9 16 9
clear
board 1 1111111111
req hard_t_top 2 0 0 4 5 0 4 0 0 3 0 4 0 5 -1 4
req rot_r_jr_top 3 1 0 4 0 0 4 2 -1 4 0 4 1 4 -1 5
req move_l_ir_top 0 1 0 3 3 0 2 1 -2 3 -1 3 0 3 1 3
req hard_i_top 0 0 0 2 5 0 2 0 0 0 0 1 0 2 0 3

/* testbench/tb_action_state_update.sv */
// ==============================
// action state update testbench
// replays the action trace and checks
// targets, ghost cells and handshakes
// ==============================

`timescale 1ns/1ps

`include "tetris_params.svh"

module tb_action_state_update
    import tetris_pkg::*;
();

    localparam int OCC_W = `PLAYFIELD_ROWS * `PLAYFIELD_COLS;

    logic               clk;
    logic               rst_n;
    logic               req_valid;
    logic               req_ready;
    tile_type_t         req_type;
    orientation_t       req_orientation;
    coord_t             req_row;
    coord_t             req_col;
    action_t            req_action;
    logic [OCC_W-1:0]   locked_occ;
    logic               resp_valid;
    logic               resp_ready;
    coord_t             resp_row;
    coord_t             resp_col;
    orientation_t       resp_orientation;
    cell_t              ghost_rows [4];
    cell_t              ghost_cols [4];

    integer             seed;
    int                 errors;
    int                 tests_passed;
    int                 tests_failed;
    int                 cycles;
    int                 cycle_limit;
    bit                 test_ok;
    logic [OCC_W-1:0]   board_img;

    // fields of the current trace request
    reg [8*32-1:0]      name;
    int                 t_type;
    int                 t_or;
    int                 t_row;
    int                 t_col;
    int                 t_act;
    int                 e_row;
    int                 e_col;
    int                 e_or;
    int                 gv [8];

    action_state_update dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .req_type         (req_type),
        .req_orientation  (req_orientation),
        .req_row          (req_row),
        .req_col          (req_col),
        .req_action       (req_action),
        .locked_occ       (locked_occ),
        .resp_valid       (resp_valid),
        .resp_ready       (resp_ready),
        .resp_row         (resp_row),
        .resp_col         (resp_col),
        .resp_orientation (resp_orientation),
        .ghost_rows       (ghost_rows),
        .ghost_cols       (ghost_cols)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n && cycle_limit > 0) begin
            cycles = cycles + 1;
            if (cycles >= cycle_limit) begin
                $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
                $display("SOME TESTS FAILED");
                $finish;
            end
        end
    end

    task automatic check_state(input reg [8*32-1:0] tname,
                               input coord_t exp_row, input coord_t act_row,
                               input coord_t exp_col, input coord_t act_col,
                               input orientation_t exp_or, input orientation_t act_or);
        if (exp_row !== act_row) begin
            $display("ERR %0s row expected %0d actual %0d", tname, exp_row, act_row);
            test_ok = 0;
        end
        if (exp_col !== act_col) begin
            $display("ERR %0s col expected %0d actual %0d", tname, exp_col, act_col);
            test_ok = 0;
        end
        if (exp_or !== act_or) begin
            $display("ERR %0s orientation expected %0d actual %0d", tname, exp_or, act_or);
            test_ok = 0;
        end
    endtask

    task automatic check_cells(input reg [8*32-1:0] tname,
                               input cell_t exp_rows [4], input cell_t exp_cols [4],
                               input cell_t act_rows [4], input cell_t act_cols [4]);
        for (int i = 0; i < 4; i++) begin
            if (exp_rows[i] !== act_rows[i] || exp_cols[i] !== act_cols[i]) begin
                $display("ERR %0s ghost%0d expected (%0d,%0d) actual (%0d,%0d)", tname, i,
                         exp_rows[i], exp_cols[i], act_rows[i], act_cols[i]);
                test_ok = 0;
            end
        end
    endtask

    // request count for the timeout limit
    task automatic count_requests(output int n);
        int            fd;
        int            rc;
        reg [8*16-1:0] tag;
        reg [8*256-1:0] rest;
        n = 0;
        fd = $fopen("testbench/action_trace.txt", "r");
        if (fd == 0) begin
            n = -1;
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "req") begin
                    n++;
                end
                rc = $fgets(rest, fd);
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test();
        cell_t        exp_rows [4];
        cell_t        exp_cols [4];
        cell_t        snap_rows [4];
        cell_t        snap_cols [4];
        coord_t       snap_row;
        coord_t       snap_col;
        orientation_t snap_or;
        bit           got;
        bit           have_snap;
        bit           changed;
        test_ok = 1;
        for (int i = 0; i < 4; i++) begin
            exp_rows[i] = cell_t'(gv[2*i]);
            exp_cols[i] = cell_t'(gv[2*i+1]);
        end
        @(posedge clk);
        locked_occ      <= board_img;
        req_valid       <= 1'b1;
        req_type        <= tile_type_t'(t_type[2:0]);
        req_orientation <= orientation_t'(t_or[1:0]);
        req_row         <= coord_t'(t_row);
        req_col         <= coord_t'(t_col);
        req_action      <= action_t'(t_act[2:0]);
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        got       = 0;
        have_snap = 0;
        while (!got) begin
            @(posedge clk);
            resp_ready      <= (($random(seed) & 3) != 0);
            // request lines carry junk once the request is taken
            req_type        <= tile_type_t'(3'($random(seed)));
            req_orientation <= orientation_t'(2'($random(seed)));
            req_row         <= coord_t'($random(seed));
            req_col         <= coord_t'($random(seed));
            req_action      <= action_t'(3'($random(seed)));
            @(negedge clk);
            if (resp_valid) begin
                if (req_ready) begin
                    $display("%0s: DUT is ready for a request while a response is pending", name);
                    test_ok = 0;
                end
                changed = (resp_row !== snap_row) || (resp_col !== snap_col) ||
                          (resp_orientation !== snap_or);
                for (int i = 0; i < 4; i++) begin
                    if (ghost_rows[i] !== snap_rows[i] || ghost_cols[i] !== snap_cols[i]) begin
                        changed = 1;
                    end
                end
                if (have_snap && changed) begin
                    $display("%0s: response payload changed while stalled", name);
                    test_ok = 0;
                end
                snap_row = resp_row;
                snap_col = resp_col;
                snap_or  = resp_orientation;
                for (int i = 0; i < 4; i++) begin
                    snap_rows[i] = ghost_rows[i];
                    snap_cols[i] = ghost_cols[i];
                end
                have_snap = 1;
                got       = resp_ready;
            end
        end
        @(posedge clk);
        resp_ready <= 1'b0;
        check_state(name, coord_t'(e_row), snap_row, coord_t'(e_col), snap_col,
                    orientation_t'(e_or[1:0]), snap_or);
        check_cells(name, exp_rows, exp_cols, snap_rows, snap_cols);
        if (test_ok) begin
            tests_passed++;
            $display("PASS %0s", name);
        end else begin
            tests_failed++;
            $display("FAIL %0s", name);
        end
    endtask

    initial begin
        int             n_req;
        int             fd;
        int             rc;
        int             brow;
        int             bmask;
        reg [8*16-1:0]  tag;
        reg [8*256-1:0] rest;
        seed            = 32'h9a50_ac4e;
        errors          = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        cycles          = 0;
        cycle_limit     = 0;
        board_img       = '0;
        rst_n           = 1'b0;
        req_valid       = 1'b0;
        req_type        = I;
        req_orientation = ORIENTATION_0;
        req_row         = '0;
        req_col         = '0;
        req_action      = ROTATE_R;
        locked_occ      = '0;
        resp_ready      = 1'b0;
        count_requests(n_req);
        if (n_req <= 0) begin
            $display("trace file is missing or holds no requests");
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            cycle_limit = n_req * (`PLAYFIELD_ROWS + 8);
            repeat (8) @(posedge clk);
            rst_n <= 1'b1;
            @(negedge clk);
            if (req_ready !== 1'b1 || resp_valid !== 1'b0) begin
                $display("after reset the DUT is not idle with req_ready high and resp_valid low");
                errors++;
            end
            fd = $fopen("testbench/action_trace.txt", "r");
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "clear") begin
                    board_img = '0;
                end else if (tag == "board") begin
                    rc = $fscanf(fd, "%d %b", brow, bmask);
                    for (int c = 0; c < `PLAYFIELD_COLS; c++) begin
                        board_img[brow * `PLAYFIELD_COLS + c] = bmask[c];
                    end
                end else if (tag == "req") begin
                    rc = $fscanf(fd, "%s %d %d %d %d %d %d %d %d", name, t_type, t_or,
                                 t_row, t_col, t_act, e_row, e_col, e_or);
                    rc = $fscanf(fd, "%d %d %d %d %d %d %d %d", gv[0], gv[1], gv[2],
                                 gv[3], gv[4], gv[5], gv[6], gv[7]);
                    run_test();
                end else if (tag != "#") begin
                    $display("trace holds a line with an unknown keyword");
                    errors++;
                end
                rc = $fgets(rest, fd);
            end
            $fclose(fd);
            $display("tests: %0d passed, %0d failed, %0d other errors",
                     tests_passed, tests_failed, errors);
            if (errors == 0 && tests_failed == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule
